//--- hw/block_mover_top.sv
`timescale 1ns/1ns
`default_nettype none

module block_mover_top (
    input  wire logic               i_Clk,
    input  wire logic               i_rst_n,
    input  wire logic               i_en,
    input  wire mover_pkg::block_t  i_start_block,
    input  wire mover_pkg::block_t  i_end_block,
    output logic                    o_step_x,
    output logic                    o_dir_x,
    output logic                    o_step_y,
    output logic                    o_dir_y,
    output logic                    o_magnet,
    output logic                    o_done
);

    mover_pkg::move_cmd_t cmd;
    logic                 cmd_valid;
    logic                 cmd_take;
    mover_pkg::axis_seg_t seg;
    logic                 seg_start_x;
    logic                 seg_start_y;
    logic                 seg_done_x;
    logic                 seg_done_y;

    cmd_capture u_capture (
        .i_Clk         (i_Clk),
        .i_rst_n       (i_rst_n),
        .i_en          (i_en),
        .i_start_block (i_start_block),
        .i_end_block   (i_end_block),
        .i_take        (cmd_take),
        .o_cmd         (cmd),
        .o_cmd_valid   (cmd_valid)
    );

    move_planner u_planner (
        .i_Clk         (i_Clk),
        .i_rst_n       (i_rst_n),
        .i_cmd         (cmd),
        .i_cmd_valid   (cmd_valid),
        .i_seg_done_x  (seg_done_x),
        .i_seg_done_y  (seg_done_y),
        .o_take        (cmd_take),
        .o_seg_start_x (seg_start_x),
        .o_seg_start_y (seg_start_y),
        .o_seg         (seg),
        .o_magnet      (o_magnet),
        .o_done        (o_done)
    );

    // both axes share the segment bus, seg_start picks the axis
    step_pulse_gen step_x (
        .i_Clk       (i_Clk),
        .i_rst_n     (i_rst_n),
        .i_seg_start (seg_start_x),
        .i_seg       (seg),
        .o_step      (o_step_x),
        .o_dir       (o_dir_x),
        .o_seg_done  (seg_done_x)
    );

    step_pulse_gen step_y (
        .i_Clk       (i_Clk),
        .i_rst_n     (i_rst_n),
        .i_seg_start (seg_start_y),
        .i_seg       (seg),
        .o_step      (o_step_y),
        .o_dir       (o_dir_y),
        .o_seg_done  (seg_done_y)
    );

endmodule

`default_nettype wire

//--- hw/cmd_capture.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_capture (
    input  wire logic                  i_Clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_en,
    input  wire mover_pkg::block_t     i_start_block,
    input  wire mover_pkg::block_t     i_end_block,
    input  wire logic                  i_take,
    output mover_pkg::move_cmd_t       o_cmd,
    output logic                       o_cmd_valid
);

    mover_pkg::move_cmd_t cmd_r;
    mover_pkg::move_cmd_t new_cmd;
    logic                 valid_r;
    logic                 accept;

    // slot is free when empty or being emptied this cycle
    assign accept = i_en && (!valid_r || i_take);

    // block number to column and row positions
    always_comb begin
        new_cmd.start_x = mover_pkg::idx_to_pos(
            int'(i_start_block) / mover_pkg::BOARD_DIM);
        new_cmd.start_y = mover_pkg::idx_to_pos(
            int'(i_start_block) % mover_pkg::BOARD_DIM);
        new_cmd.end_x = mover_pkg::idx_to_pos(
            int'(i_end_block) / mover_pkg::BOARD_DIM);
        new_cmd.end_y = mover_pkg::idx_to_pos(
            int'(i_end_block) % mover_pkg::BOARD_DIM);
    end

    always_ff @(posedge i_Clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_r <= 1'b0;
        end else if (accept) begin
            valid_r <= 1'b1;
        end else if (i_take) begin
            valid_r <= 1'b0;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (accept) begin
            cmd_r <= new_cmd;
        end
    end

    assign o_cmd = cmd_r;
    assign o_cmd_valid = valid_r;

    // planner only takes what is pending
    a_take_valid: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        i_take |-> o_cmd_valid);

endmodule

`default_nettype wire

//--- hw/move_planner.sv
`timescale 1ns/1ns
`default_nettype none

module move_planner (
    input  wire logic                  i_Clk,
    input  wire logic                  i_rst_n,
    input  wire mover_pkg::move_cmd_t  i_cmd,
    input  wire logic                  i_cmd_valid,
    input  wire logic                  i_seg_done_x,
    input  wire logic                  i_seg_done_y,
    output logic                       o_take,
    output logic                       o_seg_start_x,
    output logic                       o_seg_start_y,
    output mover_pkg::axis_seg_t       o_seg,
    output logic                       o_magnet,
    output logic                       o_done
);

    typedef enum logic [2:0] {
        S_IDLE    = 3'd0,
        S_START_X = 3'd1,
        S_START_Y = 3'd2,
        S_BLOCK_X = 3'd3,
        S_BLOCK_Y = 3'd4,
        S_RET_X   = 3'd5,
        S_RET_Y   = 3'd6,
        S_DONE    = 3'd7
    } state_t;

    state_t               state_r;
    state_t               state_nxt;
    mover_pkg::move_cmd_t cmd_r;
    logic [5:0]           seg_mask_r;
    logic [5:0]           take_mask;
    mover_pkg::pos_t      pos_x_r;
    mover_pkg::pos_t      pos_y_r;
    mover_pkg::pos_t      cur_pos;
    mover_pkg::pos_t      target;
    mover_pkg::axis_e     seg_axis;
    logic                 running_r;
    logic                 in_seg;
    logic                 seg_fire;
    logic                 seg_done;
    logic                 magnet_r;
    logic                 done_r;

    // first segment state after 'from' whose mask bit is set
    function automatic state_t next_seg(input logic [5:0] mask, input logic [2:0] from);
        state_t nxt;
        logic   found;
        nxt = S_DONE;
        found = 1'b0;
        for (int i = 1; i <= 6; i++) begin
            if (!found && (i > int'(from)) && mask[i-1]) begin
                nxt = state_t'(i);
                found = 1'b1;
            end
        end
        return nxt;
    endfunction

    // drag target runs past the end block by the excess
    function automatic mover_pkg::pos_t overshoot(input mover_pkg::pos_t from,
                                                  input mover_pkg::pos_t to);
        mover_pkg::pos_t res;
        res = to;
        if (to > from) begin
            res = to + mover_pkg::pos_t'(mover_pkg::EXCESS_STEPS);
        end else if (to < from) begin
            res = to - mover_pkg::pos_t'(mover_pkg::EXCESS_STEPS);
        end
        return res;
    endfunction

    assign o_take = (state_r == S_IDLE) && i_cmd_valid;

    // which of the six segments move at all
    always_comb begin
        take_mask[0] = (pos_x_r != i_cmd.start_x);
        take_mask[1] = (pos_y_r != i_cmd.start_y);
        take_mask[2] = (i_cmd.start_x != i_cmd.end_x);
        take_mask[3] = (i_cmd.start_y != i_cmd.end_y);
        take_mask[4] = (i_cmd.start_x != i_cmd.end_x);
        take_mask[5] = (i_cmd.start_y != i_cmd.end_y);
    end

    always_comb begin
        seg_axis = mover_pkg::AXIS_X;
        target = pos_x_r;
        case (state_r)
            S_START_X: begin
                target = cmd_r.start_x;
            end
            S_START_Y: begin
                seg_axis = mover_pkg::AXIS_Y;
                target = cmd_r.start_y;
            end
            S_BLOCK_X: begin
                target = overshoot(cmd_r.start_x, cmd_r.end_x);
            end
            S_BLOCK_Y: begin
                seg_axis = mover_pkg::AXIS_Y;
                target = overshoot(cmd_r.start_y, cmd_r.end_y);
            end
            S_RET_X: begin
                target = cmd_r.end_x;
            end
            S_RET_Y: begin
                seg_axis = mover_pkg::AXIS_Y;
                target = cmd_r.end_y;
            end
            default: begin
                target = pos_x_r;
            end
        endcase
        cur_pos = (seg_axis == mover_pkg::AXIS_X) ? pos_x_r : pos_y_r;
    end

    always_comb begin
        o_seg.dir = (target > cur_pos);
        o_seg.steps = o_seg.dir ? (target - cur_pos) : (cur_pos - target);
    end

    assign in_seg = (state_r != S_IDLE) && (state_r != S_DONE);
    assign seg_fire = in_seg && !running_r;
    assign seg_done = running_r &&
        ((seg_axis == mover_pkg::AXIS_X) ? i_seg_done_x : i_seg_done_y);

    assign o_seg_start_x = seg_fire && (seg_axis == mover_pkg::AXIS_X);
    assign o_seg_start_y = seg_fire && (seg_axis == mover_pkg::AXIS_Y);

    always_comb begin
        state_nxt = state_r;
        case (state_r)
            S_IDLE: begin
                if (o_take) begin
                    state_nxt = next_seg(take_mask, 3'd0);
                end
            end
            S_DONE: begin
                state_nxt = S_IDLE;
            end
            default: begin
                if (seg_done) begin
                    state_nxt = next_seg(seg_mask_r, state_r);
                end
            end
        endcase
    end

    always_ff @(posedge i_Clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= S_IDLE;
            seg_mask_r <= '0;
            running_r <= 1'b0;
            pos_x_r <= '0;
            pos_y_r <= '0;
            magnet_r <= 1'b0;
            done_r <= 1'b0;
        end else begin
            state_r <= state_nxt;
            magnet_r <= (state_nxt == S_BLOCK_X) || (state_nxt == S_BLOCK_Y);
            done_r <= (state_nxt == S_DONE);
            if (o_take) begin
                seg_mask_r <= take_mask;
            end
            if (seg_fire) begin
                running_r <= 1'b1;
            end else if (seg_done) begin
                running_r <= 1'b0;
            end
            // each segment lands exactly on its target
            if (seg_done) begin
                if (seg_axis == mover_pkg::AXIS_X) begin
                    pos_x_r <= target;
                end else begin
                    pos_y_r <= target;
                end
            end
        end
    end

    always_ff @(posedge i_Clk) begin
        if (o_take) begin
            cmd_r <= i_cmd;
        end
    end

    assign o_magnet = magnet_r;
    assign o_done = done_r;

    // zero-step segments are skipped and never started
    a_seg_nonzero: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        (o_seg_start_x || o_seg_start_y) |-> (o_seg.steps != '0));

    a_pos_range: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        (int'(pos_x_r) <= mover_pkg::POS_LIMIT) && (int'(pos_y_r) <= mover_pkg::POS_LIMIT));

endmodule

`default_nettype wire

//--- hw/mover_pkg.sv
`default_nettype none

package mover_pkg;

    // board geometry, 4 x 4 blocks
    localparam int BOARD_DIM = 4;
    localparam int AXIS_OFFSET = 100;
    localparam int STEPS_PER_BLOCK = 625;

    // overshoot while the magnet drags a piece
    localparam int EXCESS_STEPS = 20;

    // step pulse shape
    localparam int STEP_HALF_CYCLES = 4;
    localparam int HALF_CNT_W = (STEP_HALF_CYCLES > 1) ? $clog2(STEP_HALF_CYCLES) : 1;
    localparam logic [HALF_CNT_W-1:0] HALF_LAST = HALF_CNT_W'(STEP_HALF_CYCLES - 1);

    localparam int POS_W = 12;

    // farthest block centre plus overshoot
    localparam int POS_LIMIT = AXIS_OFFSET + (BOARD_DIM - 1) * STEPS_PER_BLOCK + EXCESS_STEPS;

    // upper two bits pick the X column, lower two the Y row
    typedef logic [3:0] block_t;

    typedef logic [POS_W-1:0] pos_t;

    typedef enum logic {
        AXIS_X = 1'b0,
        AXIS_Y = 1'b1
    } axis_e;

    typedef struct packed {
        pos_t start_x;
        pos_t start_y;
        pos_t end_x;
        pos_t end_y;
    } move_cmd_t;

    // dir high moves towards larger positions
    typedef struct packed {
        logic dir;
        pos_t steps;
    } axis_seg_t;

    // centre of a block index along one axis
    function automatic pos_t idx_to_pos(input int unsigned idx);
        return pos_t'(AXIS_OFFSET + idx * STEPS_PER_BLOCK);
    endfunction

endpackage

`default_nettype wire

//--- hw/step_pulse_gen.sv
`timescale 1ns/1ns
`default_nettype none

module step_pulse_gen (
    input  wire logic                  i_Clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_seg_start,
    input  wire mover_pkg::axis_seg_t  i_seg,
    output logic                       o_step,
    output logic                       o_dir,
    output logic                       o_seg_done
);

    logic                             busy_r;
    logic                             step_r;
    logic                             dir_r;
    logic                             done_r;
    logic [mover_pkg::HALF_CNT_W-1:0] half_cnt_r;
    mover_pkg::pos_t                  steps_left_r;
    logic                             phase_end;
    logic                             rise;

    assign phase_end = (half_cnt_r == mover_pkg::HALF_LAST);

    // end of a low phase with steps still owed
    assign rise = busy_r && phase_end && !step_r && (steps_left_r != '0);

    always_ff @(posedge i_Clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_r <= 1'b0;
            step_r <= 1'b0;
            dir_r <= 1'b0;
            done_r <= 1'b0;
            half_cnt_r <= '0;
        end else begin
            done_r <= 1'b0;
            if (i_seg_start) begin
                busy_r <= 1'b1;
                dir_r <= i_seg.dir;
                step_r <= 1'b0;
                // one low cycle so dir settles before the first edge
                half_cnt_r <= mover_pkg::HALF_LAST;
            end else if (busy_r) begin
                if (!phase_end) begin
                    half_cnt_r <= half_cnt_r + 1'b1;
                end else begin
                    half_cnt_r <= '0;
                    if (step_r) begin
                        step_r <= 1'b0;
                    end else if (rise) begin
                        step_r <= 1'b1;
                    end else begin
                        busy_r <= 1'b0;
                        done_r <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge i_Clk) begin
        if (i_seg_start) begin
            steps_left_r <= i_seg.steps;
        end else if (rise) begin
            steps_left_r <= steps_left_r - 1'b1;
        end
    end

    assign o_step = step_r;
    assign o_dir = dir_r;
    assign o_seg_done = done_r;

    // planner must wait for seg_done before the next segment
    a_no_overlap: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        i_seg_start |-> !busy_r);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the block mover testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_block_mover \
    -f sim.f -o tb_block_mover \
    && ./obj_dir/tb_block_mover 2>&1 | tee sim.log \
    || { echo "verilator build or run failed"; exit 1; }
grep -q "TB FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

//--- sim.f
hw/mover_pkg.sv
hw/cmd_capture.sv
hw/move_planner.sv
hw/step_pulse_gen.sv
hw/block_mover_top.sv
tb/tb_block_mover.sv

//--- tb/block_mover_vectors.txt
# name start end overlap net_dx net_dy magnet_x magnet_y total_pulses
# blocks 0..15, overlap 1 strobes the next line while this one runs
first_move         0  5 0   725   725  645  645 1530
same_block_idle    5  5 0     0     0    0    0    0
x_only             5 13 0  1250     0 1270    0 1290
y_only_down       13 12 0     0  -625    0  645  665
long_reposition    2  1 0 -1875   625    0  645 3790
overlap_a          1 15 1  1875  1250 1895 1270 3205
overlap_b         10  6 0 -1250  -625  645    0 1915
same_block_moved   0  0 0  -625 -1250    0    0 1875
diag_up            0 15 1  1875  1875 1895 1895 3830
overlap_c         15 14 1     0  -625    0  645  665
overlap_d         14  4 0 -1250 -1250 1270 1270 2580
x_back_one         4  0 0  -625     0  645    0  665
same_block_home    0  0 0     0     0    0    0    0
mid_board          9  6 0   625  1250  645  645 3205
last_step          7 11 0   625   625  645    0 1290

//--- tb/tb_block_mover.sv
`timescale 1ns/1ns
`default_nettype none

module tb_block_mover;

    localparam int MAX_VEC = 64;
    localparam int HALF = mover_pkg::STEP_HALF_CYCLES;
    localparam int CLK_NS = 20;
    // 8 segments of 2000 steps, two phases per step, plus margin
    localparam longint CMD_WORST_NS = longint'(8 * 2000 * 2 * HALF + 500) * CLK_NS;
    localparam int unsigned SEED = 32'h52797b4e;

    typedef logic signed [mover_pkg::POS_W:0] disp_t;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              en;
    mover_pkg::block_t start_block;
    mover_pkg::block_t end_block;
    logic              step_x;
    logic              dir_x;
    logic              step_y;
    logic              dir_y;
    logic              magnet;
    logic              done;
    logic [1:0]        step_now;
    logic [1:0]        dir_now;

    string             vec_name [MAX_VEC];
    mover_pkg::block_t vec_start [MAX_VEC];
    mover_pkg::block_t vec_end [MAX_VEC];
    logic              vec_overlap [MAX_VEC];
    int                vec_dx [MAX_VEC];
    int                vec_dy [MAX_VEC];
    int                vec_mx [MAX_VEC];
    int                vec_my [MAX_VEC];
    int                vec_total [MAX_VEC];
    int                n_vec = 0;
    logic              vec_loaded = 1'b0;

    // per command results captured at each done pulse
    int                res_dx [MAX_VEC];
    int                res_dy [MAX_VEC];
    int                res_mx [MAX_VEC];
    int                res_my [MAX_VEC];
    int                res_total [MAX_VEC];
    logic              res_mag [MAX_VEC];
    int                done_cnt = 0;
    string             cur_name = "reset";

    // index 0 is X, 1 is Y
    int                net [2] = '{0, 0};
    int                mag_steps [2] = '{0, 0};
    int                run_len [2] = '{0, 0};
    int                pulses = 0;
    logic              mag_seen = 1'b0;
    logic [1:0]        step_prev = 2'b00;
    logic [1:0]        dir_prev = 2'b00;
    logic              done_prev = 1'b0;

    block_mover_top uut (
        .i_Clk         (clk),
        .i_rst_n       (rst_n),
        .i_en          (en),
        .i_start_block (start_block),
        .i_end_block   (end_block),
        .o_step_x      (step_x),
        .o_dir_x       (dir_x),
        .o_step_y      (step_y),
        .o_dir_y       (dir_y),
        .o_magnet      (magnet),
        .o_done        (done)
    );

    always #10 clk = ~clk;

    assign step_now = {step_y, step_x};
    assign dir_now = {dir_y, dir_x};

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_pos(input string name, input mover_pkg::pos_t exp,
                             input mover_pkg::pos_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_disp(input string name, input disp_t exp, input disp_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    code;
        string tok;
        string rest;
        int    s;
        int    e;
        int    ov;
        int    dx;
        int    dy;
        int    mx;
        int    my;
        int    tot;
        logic  at_end;
        fd = $fopen("tb/block_mover_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tb/block_mover_vectors.txt");
        end else begin
            at_end = 1'b0;
            while (!at_end) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    at_end = 1'b1;
                end else if (tok.substr(0, 0) == "#") begin
                    code = $fgets(rest, fd);
                end else if (n_vec >= MAX_VEC) begin
                    abort_run("too many lines in the vector file");
                end else begin
                    code = $fscanf(fd, "%d %d %d %d %d %d %d %d",
                                   s, e, ov, dx, dy, mx, my, tot);
                    if (code != 8) begin
                        abort_run($sformatf("malformed vector line for %s", tok));
                    end else begin
                        vec_name[n_vec] = tok;
                        vec_start[n_vec] = mover_pkg::block_t'(s);
                        vec_end[n_vec] = mover_pkg::block_t'(e);
                        vec_overlap[n_vec] = (ov != 0);
                        vec_dx[n_vec] = dx;
                        vec_dy[n_vec] = dy;
                        vec_mx[n_vec] = mx;
                        vec_my[n_vec] = my;
                        vec_total[n_vec] = tot;
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
            if (n_vec == 0) begin
                abort_run("no vectors found in tb/block_mover_vectors.txt");
            end
        end
    endtask

    task automatic strobe_cmd(input mover_pkg::block_t s, input mover_pkg::block_t e);
        @(negedge clk);
        en = 1'b1;
        start_block = s;
        end_block = e;
        @(negedge clk);
        en = 1'b0;
    endtask

    task automatic check_result(input int i);
        check_disp({vec_name[i], " net x"}, disp_t'(vec_dx[i]), disp_t'(res_dx[i]));
        check_disp({vec_name[i], " net y"}, disp_t'(vec_dy[i]), disp_t'(res_dy[i]));
        check_pos({vec_name[i], " magnet steps x"}, mover_pkg::pos_t'(vec_mx[i]),
                  mover_pkg::pos_t'(res_mx[i]));
        check_pos({vec_name[i], " magnet steps y"}, mover_pkg::pos_t'(vec_my[i]),
                  mover_pkg::pos_t'(res_my[i]));
        check_pos({vec_name[i], " total pulses"}, mover_pkg::pos_t'(vec_total[i]),
                  mover_pkg::pos_t'(res_total[i]));
        check_flag({vec_name[i], " magnet used"}, (vec_mx[i] != 0) || (vec_my[i] != 0),
                   res_mag[i]);
    endtask

    // pulse counting and step shape sampled away from the active edge
    always @(negedge clk) begin
        string tag;
        if (rst_n) begin
            for (int a = 0; a < 2; a++) begin
                tag = (a == 0) ? "x" : "y";
                if (step_now[a] != step_prev[a]) begin
                    if (step_prev[a]) begin
                        check_pos($sformatf("%s high phase %s", cur_name, tag),
                                  mover_pkg::pos_t'(HALF), mover_pkg::pos_t'(run_len[a]));
                    end else if (run_len[a] != HALF && run_len[a] < HALF + 2) begin
                        abort_run($sformatf("%s: step_%s low phase lasted %0d cycles",
                                            cur_name, tag, run_len[a]));
                    end
                    run_len[a] = 1;
                end else begin
                    run_len[a]++;
                end
                if (step_now[a] && !step_prev[a]) begin
                    net[a] += dir_now[a] ? 1 : -1;
                    pulses++;
                    if (magnet) begin
                        mag_steps[a]++;
                    end
                end
                if ((step_now[a] || step_prev[a]) && (dir_now[a] != dir_prev[a])) begin
                    check_flag($sformatf("%s dir_%s steady around step", cur_name, tag),
                               dir_prev[a], dir_now[a]);
                end
            end
            if (magnet) begin
                mag_seen = 1'b1;
            end
            if (done && done_prev) begin
                abort_run("o_done stayed high for more than one cycle");
            end else if (done) begin
                if (done_cnt >= n_vec) begin
                    abort_run("o_done pulsed with no command outstanding");
                end else begin
                    res_dx[done_cnt] = net[0];
                    res_dy[done_cnt] = net[1];
                    res_mx[done_cnt] = mag_steps[0];
                    res_my[done_cnt] = mag_steps[1];
                    res_total[done_cnt] = pulses;
                    res_mag[done_cnt] = mag_seen;
                    net = '{0, 0};
                    mag_steps = '{0, 0};
                    pulses = 0;
                    mag_seen = 1'b0;
                    done_cnt++;
                end
            end
            step_prev = step_now;
            dir_prev = dir_now;
            done_prev = done;
        end
    end

    initial begin
        longint limit_ns;
        wait (vec_loaded);
        limit_ns = longint'(n_vec) * CMD_WORST_NS + 100 * CLK_NS;
        #(limit_ns);
        abort_run("timeout waiting for done");
    end

    initial begin
        int   gap;
        logic issued [MAX_VEC];
        void'($urandom(SEED));
        rst_n = 1'b0;
        en = 1'b0;
        start_block = '0;
        end_block = '0;
        for (int k = 0; k < MAX_VEC; k++) begin
            issued[k] = 1'b0;
        end
        load_vectors();
        vec_loaded = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        // reset values of the outputs
        check_flag("reset value o_step_x", 1'b0, step_x);
        check_flag("reset value o_step_y", 1'b0, step_y);
        check_flag("reset value o_magnet", 1'b0, magnet);
        check_flag("reset value o_done", 1'b0, done);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < n_vec; i++) begin
            cur_name = vec_name[i];
            if (!issued[i]) begin
                gap = int'($urandom % 8);
                repeat (gap) @(negedge clk);
                strobe_cmd(vec_start[i], vec_end[i]);
                issued[i] = 1'b1;
            end
            // queue the next command behind the running one
            if (vec_overlap[i] && (i + 1 < n_vec)) begin
                gap = int'($urandom % 8);
                repeat (3 + gap) @(posedge clk);
                check_flag({cur_name, " still running at next strobe"}, 1'b1, done_cnt <= i);
                strobe_cmd(vec_start[i + 1], vec_end[i + 1]);
                issued[i + 1] = 1'b1;
            end
            while (done_cnt <= i) begin
                @(posedge clk);
            end
            check_result(i);
        end
        repeat (50) @(posedge clk);
        check_pos("o_done pulse count", mover_pkg::pos_t'(n_vec), mover_pkg::pos_t'(done_cnt));
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
